// ==== video_timing_defines.svh ====
`ifndef VIDEO_TIMING_DEFINES_SVH
`define VIDEO_TIMING_DEFINES_SVH

`define VT_CNT_W 11 // Raster counter width
`define VT_MODE_W 4 // Mode select width

// Mode codes, same values as the board switches
`define VT_MODE_VGA    4'b0000
`define VT_MODE_SVGA   4'b0001
`define VT_MODE_HD720  4'b0010
`define VT_MODE_XGA    4'b0011
`define VT_MODE_SXGA   4'b1000
`define VT_MODE_CAMERA 4'b1001

//////////////////////////////////////////
// Per-mode geometry
//////////////////////////////////////////

// 640x480
`define VT_VGA_HPIX 11'd640
`define VT_VGA_HFP  11'd16
`define VT_VGA_HSW  11'd96
`define VT_VGA_HBP  11'd48
`define VT_VGA_VLIN 11'd480
`define VT_VGA_VFP  11'd11
`define VT_VGA_VSW  11'd2
`define VT_VGA_VBP  11'd31
`define VT_VGA_POL  1'b1   // Negative sync

// 800x600
`define VT_SVGA_HPIX 11'd800
`define VT_SVGA_HFP  11'd40
`define VT_SVGA_HSW  11'd128
`define VT_SVGA_HBP  11'd88
`define VT_SVGA_VLIN 11'd600
`define VT_SVGA_VFP  11'd1
`define VT_SVGA_VSW  11'd4
`define VT_SVGA_VBP  11'd23
`define VT_SVGA_POL  1'b0

// 1024x768
`define VT_XGA_HPIX 11'd1024
`define VT_XGA_HFP  11'd24
`define VT_XGA_HSW  11'd136
`define VT_XGA_HBP  11'd160
`define VT_XGA_VLIN 11'd768
`define VT_XGA_VFP  11'd3
`define VT_XGA_VSW  11'd6
`define VT_XGA_VBP  11'd29
`define VT_XGA_POL  1'b1   // Negative sync

// 1280x720, also the fallback mode
`define VT_HD720_HPIX 11'd1280
`define VT_HD720_HFP  11'd110
`define VT_HD720_HSW  11'd40
`define VT_HD720_HBP  11'd220
`define VT_HD720_VLIN 11'd720
`define VT_HD720_VFP  11'd5
`define VT_HD720_VSW  11'd5
`define VT_HD720_VBP  11'd20
`define VT_HD720_POL  1'b0

// 1280x1024
`define VT_SXGA_HPIX 11'd1280
`define VT_SXGA_HFP  11'd48
`define VT_SXGA_HSW  11'd112
`define VT_SXGA_HBP  11'd248
`define VT_SXGA_VLIN 11'd1024
`define VT_SXGA_VFP  11'd1
`define VT_SXGA_VSW  11'd3
`define VT_SXGA_VBP  11'd38
`define VT_SXGA_POL  1'b0

// Camera, 720p with trimmed sync widths
`define VT_CAMERA_HPIX 11'd1280
`define VT_CAMERA_HFP  11'd110
`define VT_CAMERA_HSW  11'd39
`define VT_CAMERA_HBP  11'd220
`define VT_CAMERA_VLIN 11'd720
`define VT_CAMERA_VFP  11'd4
`define VT_CAMERA_VSW  11'd4
`define VT_CAMERA_VBP  11'd22
`define VT_CAMERA_POL  1'b0

`endif

// ==== video_timing_pkg.sv ====
`default_nettype none

`include "video_timing_defines.svh"

package video_timing_pkg;

	// Threshold set for one display mode
	typedef struct packed {
		logic [`VT_CNT_W-1:0] hsblnk; // Last active pixel
		logic [`VT_CNT_W-1:0] hssync; // Last pixel before hsync
		logic [`VT_CNT_W-1:0] hesync; // Last hsync pixel
		logic [`VT_CNT_W-1:0] heblnk; // Last pixel of the line
		logic [`VT_CNT_W-1:0] vsblnk;
		logic [`VT_CNT_W-1:0] vssync;
		logic [`VT_CNT_W-1:0] vesync;
		logic [`VT_CNT_W-1:0] veblnk;
		logic                 polarity; // 1 = negative sync
	} timing_cfg_t;

	// Counter state, flags active high
	typedef struct packed {
		logic [`VT_CNT_W-1:0] hcount;
		logic [`VT_CNT_W-1:0] vcount;
		logic                 hblnk;
		logic                 vblnk;
		logic                 hsync;
		logic                 vsync;
	} raster_t;

	// Output side, sync already at line polarity
	typedef struct packed {
		logic                 hsync;
		logic                 vsync;
		logic                 de;
		logic [`VT_CNT_W-1:0] x;
		logic [`VT_CNT_W-1:0] y;
	} video_out_t;

endpackage

`default_nettype wire

// ==== mode_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_timing_defines.svh"

module mode_decode (
	input  logic                          clk50m_bufg,
	input  logic                          serdes_rst,
	input  logic                          mode_req,
	input  logic [`VT_MODE_W-1:0]         mode_code,
	output logic                          mode_ack,
	output video_timing_pkg::timing_cfg_t cfg,
	output logic                          restart
);

	typedef enum logic [1:0] {
		ST_IDLE, // Waiting for a request
		ST_LOAD, // Threshold set follows the new code
		ST_ARM,  // Ack and restart go out next edge
		ST_HOLD  // Ack high until req drops
	} hs_state_t;

	hs_state_t             state;
	logic [`VT_MODE_W-1:0] mode_q; // Accepted mode

	// Thresholds are running sums from the last active pixel
	function automatic video_timing_pkg::timing_cfg_t build_cfg(
		input logic [`VT_CNT_W-1:0] hpix, hfp, hsw, hbp,
		input logic [`VT_CNT_W-1:0] vlin, vfp, vsw, vbp,
		input logic                 pol
	);
		video_timing_pkg::timing_cfg_t c;
		c.hsblnk   = hpix - 11'd1;
		c.hssync   = c.hsblnk + hfp;
		c.hesync   = c.hssync + hsw;
		c.heblnk   = c.hesync + hbp;
		c.vsblnk   = vlin - 11'd1;
		c.vssync   = c.vsblnk + vfp;
		c.vesync   = c.vssync + vsw;
		c.veblnk   = c.vesync + vbp;
		c.polarity = pol;
		return c;
	endfunction

	function automatic video_timing_pkg::timing_cfg_t mode_cfg(
		input logic [`VT_MODE_W-1:0] code
	);
		case (code)
			`VT_MODE_VGA: return build_cfg(`VT_VGA_HPIX, `VT_VGA_HFP, `VT_VGA_HSW,
				`VT_VGA_HBP, `VT_VGA_VLIN, `VT_VGA_VFP, `VT_VGA_VSW, `VT_VGA_VBP,
				`VT_VGA_POL);
			`VT_MODE_SVGA: return build_cfg(`VT_SVGA_HPIX, `VT_SVGA_HFP, `VT_SVGA_HSW,
				`VT_SVGA_HBP, `VT_SVGA_VLIN, `VT_SVGA_VFP, `VT_SVGA_VSW, `VT_SVGA_VBP,
				`VT_SVGA_POL);
			`VT_MODE_XGA: return build_cfg(`VT_XGA_HPIX, `VT_XGA_HFP, `VT_XGA_HSW,
				`VT_XGA_HBP, `VT_XGA_VLIN, `VT_XGA_VFP, `VT_XGA_VSW, `VT_XGA_VBP,
				`VT_XGA_POL);
			`VT_MODE_SXGA: return build_cfg(`VT_SXGA_HPIX, `VT_SXGA_HFP, `VT_SXGA_HSW,
				`VT_SXGA_HBP, `VT_SXGA_VLIN, `VT_SXGA_VFP, `VT_SXGA_VSW, `VT_SXGA_VBP,
				`VT_SXGA_POL);
			`VT_MODE_CAMERA: return build_cfg(`VT_CAMERA_HPIX, `VT_CAMERA_HFP,
				`VT_CAMERA_HSW, `VT_CAMERA_HBP, `VT_CAMERA_VLIN, `VT_CAMERA_VFP,
				`VT_CAMERA_VSW, `VT_CAMERA_VBP, `VT_CAMERA_POL);
			default: return build_cfg(`VT_HD720_HPIX, `VT_HD720_HFP, `VT_HD720_HSW,
				`VT_HD720_HBP, `VT_HD720_VLIN, `VT_HD720_VFP, `VT_HD720_VSW,
				`VT_HD720_VBP, `VT_HD720_POL); // HD720 and unknown codes
		endcase
	endfunction

	////////////////////////////////////////
	// Four-phase req/ack
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			state    <= ST_IDLE;
			mode_q   <= `VT_MODE_HD720;
			mode_ack <= 1'b0;
			restart  <= 1'b0;
		end else begin
			restart <= 1'b0; // Single-cycle pulse
			case (state)
				ST_IDLE: if (mode_req && !mode_ack) begin
					mode_q <= mode_code; // Code is stable while req is high
					state  <= ST_LOAD;
				end
				ST_LOAD: state <= ST_ARM;
				ST_ARM: begin
					mode_ack <= 1'b1;
					restart  <= 1'b1; // Counters start over with the new set
					state    <= ST_HOLD;
				end
				ST_HOLD: if (!mode_req) begin
					mode_ack <= 1'b0;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Registered threshold set, one cycle behind mode_q
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst)
			cfg <= mode_cfg(`VT_MODE_HD720);
		else
			cfg <= mode_cfg(mode_q);
	end

endmodule

`default_nettype wire

// ==== raster_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_timing_defines.svh"

module raster_counter (
	input  logic                          clk50m_bufg,
	input  logic                          serdes_rst,
	input  logic                          restart,
	input  video_timing_pkg::timing_cfg_t cfg,
	output video_timing_pkg::raster_t     raster
);

	logic [`VT_CNT_W-1:0] h_nxt; // Count after this edge
	logic [`VT_CNT_W-1:0] v_nxt;
	logic                 h_wrap; // Last pixel of the line
	logic                 v_wrap; // Last line of the frame

	////////////////////////////////////////
	// Next count
	////////////////////////////////////////
	always_comb begin
		// >= so a shorter new mode cannot run past its end
		h_wrap = raster.hcount >= cfg.heblnk;
		v_wrap = raster.vcount >= cfg.veblnk;

		if (restart)
			h_nxt = '0;
		else if (h_wrap)
			h_nxt = '0;
		else
			h_nxt = raster.hcount + 11'd1;

		if (restart)
			v_nxt = '0;
		else if (h_wrap && v_wrap)
			v_nxt = '0; // End of frame
		else if (h_wrap)
			v_nxt = raster.vcount + 11'd1;
		else
			v_nxt = raster.vcount; // Hold within the line
	end

	////////////////////////////////////////
	// Counts and flags
	////////////////////////////////////////
	// Flags come from the next count, so they line up with it
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			raster <= '0;
		end else begin
			raster.hcount <= h_nxt;
			raster.vcount <= v_nxt;
			raster.hblnk  <= h_nxt > cfg.hsblnk; // Past the active pixels
			raster.vblnk  <= v_nxt > cfg.vsblnk;
			raster.hsync  <= (h_nxt > cfg.hssync) && (h_nxt <= cfg.hesync);
			raster.vsync  <= (v_nxt > cfg.vssync) && (v_nxt <= cfg.vesync);
		end
	end

endmodule

`default_nettype wire

// ==== sync_output.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_timing_defines.svh"

module sync_output (
	input  logic                          clk50m_bufg,
	input  logic                          serdes_rst,
	input  video_timing_pkg::timing_cfg_t cfg,
	input  video_timing_pkg::raster_t     raster,
	output video_timing_pkg::video_out_t  video
);

	logic                 hsync_d1, hsync_d2;
	logic                 vsync_d1, vsync_d2;
	logic                 de_d1, de_d2;
	logic [`VT_CNT_W-1:0] x_d1, x_d2; // Position follows de
	logic [`VT_CNT_W-1:0] y_d1, y_d2;
	logic                 active;

	assign active = !raster.hblnk && !raster.vblnk; // Inside both active windows

	// Sync and de, two stages
	always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
		if (serdes_rst) begin
			hsync_d1 <= `VT_HD720_POL; // Idle level of the reset mode
			vsync_d1 <= `VT_HD720_POL;
			de_d1    <= 1'b0;
			hsync_d2 <= `VT_HD720_POL;
			vsync_d2 <= `VT_HD720_POL;
			de_d2    <= 1'b0;
		end else begin
			hsync_d1 <= raster.hsync ^ cfg.polarity; // Invert for negative modes
			vsync_d1 <= raster.vsync ^ cfg.polarity;
			de_d1    <= active;
			hsync_d2 <= hsync_d1;
			vsync_d2 <= vsync_d1;
			de_d2    <= de_d1;
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		x_d1 <= raster.hcount;
		y_d1 <= raster.vcount;
		x_d2 <= x_d1;
		y_d2 <= y_d1;
	end

	assign video = '{hsync: hsync_d2, vsync: vsync_d2, de: de_d2, x: x_d2, y: y_d2};

endmodule

`default_nettype wire

// ==== video_timing_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_timing_defines.svh"

module video_timing_top (
	input  logic                         clk50m_bufg,
	input  logic                         serdes_rst,
	input  logic                         mode_req,
	input  logic [`VT_MODE_W-1:0]        mode_code,
	output logic                         mode_ack,
	output video_timing_pkg::video_out_t video
);

	video_timing_pkg::timing_cfg_t cfg;     // Active threshold set
	video_timing_pkg::raster_t     raster;  // Counts and raw flags
	logic                          restart; // Counters back to 0

	// Decode
	mode_decode u_mode_decode (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.mode_req    (mode_req),
		.mode_code   (mode_code),
		.mode_ack    (mode_ack),
		.cfg         (cfg),
		.restart     (restart)
	);

	// Execute
	raster_counter u_raster_counter (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.restart     (restart),
		.cfg         (cfg),
		.raster      (raster)
	);

	// Result
	sync_output u_sync_output (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.cfg         (cfg),
		.raster      (raster),
		.video       (video)
	);

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_timing_defines.svh"

module tb_checker (
	input  wire logic                         clk50m_bufg,
	input  wire logic                         serdes_rst,
	input  wire logic                         mode_req,
	input  wire logic                         mode_ack,
	input  wire video_timing_pkg::video_out_t video,
	input  wire logic                         arm,       // New test record valid
	input  wire logic [31:0]                  exp_full,  // 1 = whole frame
	input  wire logic [31:0]                  exp_htotal,
	input  wire logic [31:0]                  exp_hsw,
	input  wire logic [31:0]                  exp_hpix,
	input  wire logic [31:0]                  exp_vtotal,
	input  wire logic [31:0]                  exp_vsw,
	input  wire logic [31:0]                  exp_vlin,
	input  wire logic [31:0]                  exp_pol,
	output logic                              done,
	output int                                err_cnt
);

	int   cyc = 0, req_cyc = 0, fall_cyc = 0, start_cyc = 0, end_cyc = 0;
	logic req_q = 0, ack_q = 0, seen_req = 0, pending = 0, measuring = 0;
	logic hs_prev, vs_prev, de_prev, hs_act, vs_act;
	int   hs_len, vs_len, de_len, hs_edges, vs_edges, hs_last, de_runs;

	initial begin
		done    = 1'b0;
		err_cnt = 0;
	end

	task automatic report_error(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		err_cnt++;
	endtask

	//////////////////////////////////////////
	// Sampled on the falling edge away from drive and update
	//////////////////////////////////////////
	always @(negedge clk50m_bufg) begin
		cyc = cyc + 1;
		if (serdes_rst) begin
			if (video.de || video.hsync || video.vsync || mode_ack)
				report_error("outputs not idle during reset");
		end else begin
			if (!seen_req && !mode_req && (mode_ack || video.hsync || video.vsync))
				report_error("ack or sync active before first request");
			if (arm)
				done = 1'b0;
			if (mode_req && !req_q) begin
				seen_req = 1'b1;
				req_cyc  = cyc;
			end
			if (!mode_req && req_q)
				fall_cyc = cyc;
			if (mode_ack && !ack_q) begin
				// One cycle to reach the DUT edge and two more to ack
				if (cyc - req_cyc != 3)
					report_error($sformatf("ack rose %0d cycles after req", cyc - req_cyc));
				start_cyc = cyc + 3; // Restart count plus two output stages
				pending   = 1'b1;
				measuring = 1'b0;
			end
			if (!mode_ack && ack_q && cyc - fall_cyc != 1)
				report_error("ack did not fall one cycle after req");

			if (pending && cyc == start_cyc) begin
				// First active pixel of the new mode
				if (!video.de || video.x != 0 || video.y != 0)
					report_error("first de not at x=0 y=0 three cycles after ack");
				if (video.hsync != exp_pol[0] || video.vsync != exp_pol[0])
					report_error("sync idle level does not match polarity");
				hs_prev  = 1'b0;
				vs_prev  = 1'b0;
				de_prev  = 1'b1;
				hs_len   = 0;
				vs_len   = 0;
				de_len   = 1;
				hs_edges = 0;
				vs_edges = 0;
				de_runs  = 0;
				hs_last  = cyc;
				end_cyc  = cyc + (exp_full[0] ? exp_htotal * exp_vtotal : 4 * exp_htotal);
				pending   = 1'b0;
				measuring = 1'b1;
			end else if (measuring && cyc == end_cyc) begin
				// Next line or next frame must start right here
				if (!video.de || video.x != 0 || video.y != (exp_full[0] ? 0 : 4))
					report_error("window end not at start of next line or frame");
				if (hs_edges != (exp_full[0] ? exp_vtotal : 4))
					report_error($sformatf("%0d hsync pulses in window", hs_edges));
				if (vs_edges != (exp_full[0] ? 1 : 0))
					report_error($sformatf("%0d vsync pulses in window", vs_edges));
				if (de_runs != (exp_full[0] ? exp_vlin : 4))
					report_error($sformatf("%0d lines with de, wrong count", de_runs));
				measuring = 1'b0;
				done      = 1'b1;
			end else if (measuring) begin
				hs_act = video.hsync != exp_pol[0];
				vs_act = video.vsync != exp_pol[0];
				if (hs_act && !hs_prev) begin
					if (hs_edges > 0 && cyc - hs_last != exp_htotal)
						report_error($sformatf("line total %0d", cyc - hs_last));
					hs_edges++;
					hs_last = cyc;
					hs_len  = 0;
				end
				if (hs_act)
					hs_len++;
				else if (hs_prev && hs_len != exp_hsw)
					report_error($sformatf("hsync width %0d", hs_len));
				if (vs_act && !vs_prev) begin
					vs_edges++;
					vs_len = 0;
				end
				if (vs_act)
					vs_len++;
				else if (vs_prev && vs_len != exp_vsw * exp_htotal)
					report_error($sformatf("vsync width %0d cycles", vs_len));
				if (video.de) begin
					if (int'(video.x) != de_len || int'(video.y) != de_runs)
						report_error($sformatf("position x=%0d y=%0d", video.x, video.y));
					de_len++;
				end else if (de_prev) begin
					if (de_len != exp_hpix)
						report_error($sformatf("de width %0d", de_len));
					de_runs++;
					de_len = 0;
				end
				hs_prev = hs_act;
				vs_prev = vs_act;
				de_prev = video.de;
			end
		end
		req_q = mode_req;
		ack_q = mode_ack;
	end

endmodule

`default_nettype wire

// ==== tb_video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_timing_defines.svh"

module tb_video_timing;

	localparam int MAX_TESTS = 16;

	logic                         clk50m_bufg;
	logic                         serdes_rst;
	logic                         mode_req;
	logic [`VT_MODE_W-1:0]        mode_code;
	logic                         mode_ack;
	video_timing_pkg::video_out_t video;
	logic                         arm;
	logic                         done;
	int                           err_cnt;
	logic [31:0] exp_full, exp_htotal, exp_hsw, exp_hpix;
	logic [31:0] exp_vtotal, exp_vsw, exp_vlin, exp_pol;

	int     g_code[MAX_TESTS], g_full[MAX_TESTS], g_htot[MAX_TESTS], g_hsw[MAX_TESTS];
	int     g_hpix[MAX_TESTS], g_vtot[MAX_TESTS], g_vsw[MAX_TESTS], g_vlin[MAX_TESTS];
	int     g_pol[MAX_TESTS];
	int     n_tests = 0;
	int     tb_errors = 0;
	int     cycle = 0;
	int     limit = 0; // Timeout in cycles

	video_timing_top uut (
		.clk50m_bufg (clk50m_bufg),
		.serdes_rst  (serdes_rst),
		.mode_req    (mode_req),
		.mode_code   (mode_code),
		.mode_ack    (mode_ack),
		.video       (video)
	);

	tb_checker u_checker (.*);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	// Cycle limit at 1.25x the summed test lengths
	always @(posedge clk50m_bufg) begin
		cycle = cycle + 1;
		if (limit > 0 && cycle >= limit) begin
			$display("Run timed out after %0d cycles", cycle);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic load_golden();
		int    fd;
		int    n;
		string line;
		fd = $fopen("video_timing_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file");
			tb_errors++;
			return;
		end
		while ($fgets(line, fd) != 0 && n_tests < MAX_TESTS) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue; // Header or blank
			n = $sscanf(line, "%h %d %d %d %d %d %d %d %d", g_code[n_tests],
				g_full[n_tests], g_htot[n_tests], g_hsw[n_tests], g_hpix[n_tests],
				g_vtot[n_tests], g_vsw[n_tests], g_vlin[n_tests], g_pol[n_tests]);
			if (n != 9) begin
				$display("Malformed line in the golden file");
				tb_errors++;
				continue;
			end
			limit += g_full[n_tests] ? g_htot[n_tests] * g_vtot[n_tests] : 4 * g_htot[n_tests];
			n_tests++;
		end
		$fclose(fd);
		limit = limit * 5 / 4;
		if (n_tests == 0) begin
			$display("Golden file holds no tests");
			tb_errors++;
		end
	endtask

	// Handshake one record and wait for the checker
	task automatic run_test(input int i);
		int gap;
		gap = $urandom % 8; // Idle gap 0..7
		repeat (gap) @(posedge clk50m_bufg);
		@(posedge clk50m_bufg);
		#2;
		exp_full   = g_full[i];
		exp_htotal = g_htot[i];
		exp_hsw    = g_hsw[i];
		exp_hpix   = g_hpix[i];
		exp_vtotal = g_vtot[i];
		exp_vsw    = g_vsw[i];
		exp_vlin   = g_vlin[i];
		exp_pol    = g_pol[i];
		mode_code  = g_code[i][`VT_MODE_W-1:0];
		mode_req   = 1'b1;
		arm        = 1'b1;
		do begin
			@(posedge clk50m_bufg);
			#2;
			arm = 1'b0;
		end while (!mode_ack);
		mode_req = 1'b0;
		do begin
			@(posedge clk50m_bufg);
			#2;
		end while (mode_ack || !done);
	endtask

	initial begin
		void'($urandom(32'h5134));
		clk50m_bufg = 1'b0;
		serdes_rst  = 1'b1;
		mode_req    = 1'b0;
		mode_code   = `VT_MODE_HD720;
		arm         = 1'b0;
		{exp_full, exp_htotal, exp_hsw, exp_hpix} = '0;
		{exp_vtotal, exp_vsw, exp_vlin, exp_pol}  = '0;
		load_golden();
		repeat (16) @(posedge clk50m_bufg);
		#2 serdes_rst = 1'b0;
		for (int i = 0; i < n_tests; i++)
			run_test(i);
		@(posedge clk50m_bufg);
		$display("Closing: %0d checker errors, %0d testbench errors", err_cnt, tb_errors);
		if (err_cnt == 0 && tb_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== video_timing.f ====
+incdir+.
video_timing_pkg.sv
mode_decode.sv
raster_counter.sv
sync_output.sv
video_timing_top.sv
tb_checker.sv
tb_video_timing.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f video_timing.f \
	--top-module tb_video_timing -o sim_video_timing > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_video_timing > sim.log 2>&1 \
	|| { echo "Simulation did not exit cleanly, see sim.log"; exit 1; }

grep -q "^TESTS PASSED$" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== video_timing_golden.txt ====
# code(hex) full htotal hsw hpix vtotal vsw vlin pol
# full: 1 = whole frame checked, 0 = four lines; pol: 1 = negative sync
0 1 800 96 640 524 2 480 1
1 1 1056 128 800 628 4 600 0
3 0 1344 136 1024 806 6 768 1
2 0 1650 40 1280 750 5 720 0
8 0 1688 112 1280 1066 3 1024 0
9 0 1649 39 1280 750 4 720 0
f 0 1650 40 1280 750 5 720 0
